//--- design/cpuPkg.sv
// Opcode, function and ALU codes for the control path
// Host address map and the decode and branch stage bundles
package cpuPkg;

	localparam int pcWidth = 9;
	localparam int imemDepth = 128;
	localparam int imemAdrxWidth = $clog2(imemDepth);

	// Primary opcodes in bits 31 to 26
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2B;
	localparam logic [5:0] opBeqz = 6'h04;
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] opJr = 6'h06;
	localparam logic [5:0] opHalt = 6'h3F;

	// R-type function field
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2A;

	// Host map, one word per instruction from base to last
	localparam logic [11:0] hostImemBase = 12'h000;
	localparam logic [11:0] hostImemLast = 12'h1FC;
	localparam logic [11:0] hostCtrlAddr = 12'h200;
	localparam logic [11:0] hostStatusAddr = 12'h204;

	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr = 3'd3,
		aluSlt = 3'd4
	} aluCtlT;

	typedef enum logic [1:0] {
		brNone = 2'd0,
		brJump = 2'd1,
		brJumpReg = 2'd2,
		brZero = 2'd3
	} branchKindT;

	typedef struct packed {
		logic [4:0] rfRdAdrx0;
		logic [4:0] rfRdAdrx1;
		logic [4:0] rfWrAdrx;
		aluCtlT aluCtl;
		logic rfWriteEn;
		logic aluBusBSel;
		logic dmemResultSel;
		logic dmemWrite;
		logic regDest;
		logic [15:0] immediate;
		logic halt;
	} decodeT;

	typedef struct packed {
		branchKindT kind;
		logic [15:0] imm;
	} branchT;

	// Idle bundles, all controls off
	localparam decodeT decodeIdle = '0;
	localparam branchT branchIdle = '{kind: brNone, imm: 16'h0000};

endpackage

//--- design/decodeBus.sv
// Registered decode control bundle
// Source side is the decode stage register, sink side the decode outputs
`timescale 1ns/100ps

interface decodeBus;
	import cpuPkg::*;

	decodeT ctl;

	// Written by the decode stage register
	modport source (
		output ctl
	);

	// Read by the top-level decode ports
	modport sink (
		input ctl
	);

endinterface

//--- design/stageReg.sv
// Pipeline stage register for any payload type
// Falls back to the idle value on reset or when the stage is disabled
`timescale 1ns/100ps

module stageReg #(
	parameter type payloadT = logic [31:0],
	parameter payloadT idleValue = '0
) (
	input logic clk,
	input logic reset,
	input logic en,
	input payloadT d,
	output payloadT q
);

	always_ff @(posedge clk) begin
		if (reset || !en) begin
			q <= idleValue;
		end else begin
			q <= d;
		end
	end

endmodule

//--- design/programCounter.sv
// Byte-address program counter
// Held at zero while stopped, frozen by halt, loaded on redirect
`timescale 1ns/100ps

module programCounter (
	input logic clk,
	input logic reset,
	input logic run,
	input logic halt,
	input logic redirect,
	input logic [cpuPkg::pcWidth-1:0] target,
	output logic [cpuPkg::pcWidth-1:0] pc
);
	import cpuPkg::*;

	always_ff @(posedge clk) begin
		if (reset || !run) begin
			pc <= '0;
		end else if (halt) begin
			// Halt wins over a branch still in flight
			pc <= pc;
		end else if (redirect) begin
			pc <= target;
		end else begin
			pc <= pc + pcWidth'(4);
		end
	end

	// Fetch indexes words, so the PC never leaves word alignment
	pcAligned: assert property (@(posedge clk) disable iff (reset)
		pc[1:0] == 2'b00)
		else $error("pc lost word alignment: %h", pc);

endmodule

//--- design/instrMem.sv
// Instruction memory, 128 words of 32 bits
// Combinational read for fetch, clocked write from the host
`timescale 1ns/100ps

module instrMem (
	input logic clk,
	input logic [cpuPkg::imemAdrxWidth-1:0] rdAdrx,
	output logic [31:0] rdData,
	input logic we,
	input logic [cpuPkg::imemAdrxWidth-1:0] wrAdrx,
	input logic [31:0] wrData
);
	import cpuPkg::*;

	logic [31:0] mem [imemDepth];

	// Program load from the host
	always_ff @(posedge clk) begin
		if (we) begin
			mem[wrAdrx] <= wrData;
		end
	end

	// fetch sees a host write from the next cycle on
	assign rdData = mem[rdAdrx];

endmodule

//--- design/instrDecoder.sv
// Instruction decoder
// Splits a fetched word into register addresses, controls, immediate and branch kind
`timescale 1ns/100ps

module instrDecoder (
	input logic [31:0] instruction,
	output cpuPkg::decodeT ctl,
	output cpuPkg::branchT branch
);
	import cpuPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;
	logic [15:0] imm;

	assign opcode = instruction[31:26];
	assign rs = instruction[25:21];
	assign rt = instruction[20:16];
	assign rd = instruction[15:11];
	assign imm = instruction[15:0];
	assign funct = instruction[5:0];

	always_comb begin
		logic known;
		known = 1'b1;
		ctl = decodeIdle;
		branch = branchIdle;
		case (opcode)
			opRType: begin
				ctl.rfWrAdrx = rd;
				ctl.regDest = 1'b1;
				ctl.rfWriteEn = 1'b1;
				case (funct)
					fnAdd: ctl.aluCtl = aluAdd;
					fnSub: ctl.aluCtl = aluSub;
					fnAnd: ctl.aluCtl = aluAnd;
					fnOr: ctl.aluCtl = aluOr;
					fnSlt: ctl.aluCtl = aluSlt;
					default: known = 1'b0;
				endcase
			end
			opAddi, opLw: begin
				ctl.rfWrAdrx = rt;
				ctl.rfWriteEn = 1'b1;
				ctl.aluBusBSel = 1'b1;
				ctl.dmemResultSel = (opcode == opLw);
			end
			opSw: begin
				ctl.aluBusBSel = 1'b1;
				ctl.dmemWrite = 1'b1;
			end
			opBeqz: branch = '{kind: brZero, imm: imm};
			opJ: branch = '{kind: brJump, imm: imm};
			opJr: branch = '{kind: brJumpReg, imm: imm};
			// Halt carries no fields so the decode outputs stay idle
			opHalt: known = 1'b0;
			default: known = 1'b0;
		endcase

		if (known) begin
			ctl.rfRdAdrx0 = rs;
			ctl.rfRdAdrx1 = rt;
			ctl.immediate = imm;
		end else begin
			ctl = decodeIdle;
		end
		ctl.halt = (opcode == opHalt);
	end

endmodule

//--- design/branchResolve.sv
// Writeback branch resolution
// Captures the execute flag and register data, carries the PC along the pipe
`timescale 1ns/100ps

module branchResolve (
	input logic clk,
	input logic reset,
	input logic [cpuPkg::pcWidth-1:0] pc,
	input cpuPkg::branchT wbBranch,
	input logic execZFlag,
	input logic [cpuPkg::pcWidth-1:0] execRfRdData0,
	output logic redirect,
	output logic [cpuPkg::pcWidth-1:0] target
);
	import cpuPkg::*;

	logic [pcWidth-1:0] pcFetch;
	logic [pcWidth-1:0] pcDecode;
	logic [pcWidth-1:0] pcExec;
	logic [pcWidth-1:0] pcWb;
	logic [pcWidth-1:0] wbRfRdData0;
	logic [pcWidth-1:0] immWord;
	logic wbZFlag;

	// PC delay line, one step per stage
	always_ff @(posedge clk) begin
		pcFetch <= pc;
		pcDecode <= pcFetch;
		pcExec <= pcDecode;
		pcWb <= pcExec;
		wbRfRdData0 <= execRfRdData0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wbZFlag <= 1'b0;
		end else begin
			wbZFlag <= execZFlag;
		end
	end

	// Signed word offset, truncated to the PC width
	assign immWord = {wbBranch.imm[pcWidth-3:0], 2'b00};

	always_comb begin
		redirect = 1'b0;
		target = pcWb + pcWidth'(4) + immWord;
		case (wbBranch.kind)
			brJump: begin
				redirect = 1'b1;
				target = immWord;
			end
			brJumpReg: begin
				redirect = 1'b1;
				target = {wbRfRdData0[pcWidth-1:2], 2'b00};
			end
			brZero: redirect = wbZFlag;
			default: redirect = 1'b0;
		endcase
	end

endmodule

//--- design/hostRegs.sv
// AXI4-Lite slave for the host
// Program load window, run control register and status register
`timescale 1ns/100ps

module hostRegs (
	input logic clk,
	input logic reset,
	input logic [11:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [11:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic imemWe,
	output logic [cpuPkg::imemAdrxWidth-1:0] imemAdrx,
	output logic [31:0] imemData,
	output logic run,
	input logic halt,
	input logic [cpuPkg::pcWidth-1:0] pc
);
	import cpuPkg::*;

	logic writeStart;
	logic writeFire;
	logic readStart;
	logic readFire;
	logic inImem;
	logic isCtrl;
	logic halted;
	logic [31:0] statusWord;

	// Address and data are taken together, one write at a time
	assign writeStart = awvalid && wvalid && !awready && !bvalid;
	assign writeFire = awvalid && awready && wvalid && wready;
	assign readStart = arvalid && !arready && !rvalid;
	assign readFire = arvalid && arready;

	assign inImem = (awaddr >= hostImemBase) && (awaddr <= hostImemLast);
	assign isCtrl = (awaddr == hostCtrlAddr);

	assign imemWe = writeFire && inImem && (&wstrb);
	assign imemAdrx = awaddr[imemAdrxWidth+1:2];
	assign imemData = wdata;

	assign statusWord = {14'b0, pc, 8'b0, halted};
	assign rresp = respOkay;

	always_ff @(posedge clk) begin
		if (reset) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
			run <= 1'b0;
			halted <= 1'b0;
		end else begin
			awready <= writeStart;
			wready <= writeStart;
			arready <= readStart;
			if (writeFire) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (readFire) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
			if (writeFire && isCtrl && wstrb[0]) begin
				run <= wdata[0];
			end
			// Sticky until the CPU is stopped
			if (!run) begin
				halted <= 1'b0;
			end else if (halt) begin
				halted <= 1'b1;
			end
		end
	end

	// Response payloads
	always_ff @(posedge clk) begin
		if (writeFire) begin
			bresp <= (inImem || isCtrl || awaddr == hostStatusAddr) ? respOkay : respSlvErr;
		end
		if (readFire) begin
			case (araddr)
				hostCtrlAddr: rdata <= {31'b0, run};
				hostStatusAddr: rdata <= statusWord;
				default: rdata <= '0;
			endcase
		end
	end

	awvalidHeld: assert property (@(posedge clk) disable iff (reset)
		awvalid && !awready |=> awvalid)
		else $error("awvalid dropped before awready");

endmodule

//--- design/cpuControl.sv
// Control half of the pipelined CPU
// Fetch, decode and branch stages plus the host register block
// Decode controls leave as plain ports for the external datapath
`timescale 1ns/100ps

module cpuControl (
	input logic clk,
	input logic reset,
	input logic [11:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [11:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input logic execZFlag,
	input logic [cpuPkg::pcWidth-1:0] execRfRdData0,
	output logic [4:0] decodeRfRdAdrx0,
	output logic [4:0] decodeRfRdAdrx1,
	output logic [4:0] decodeRfWrAdrx,
	output logic [2:0] decodeAluCtl,
	output logic decodeRfWriteEn,
	output logic decodeAluBusBSel,
	output logic decodeDmemResultSel,
	output logic decodeDmemWrite,
	output logic decodeRegDest,
	output logic [15:0] decodeImmediate
);
	import cpuPkg::*;

	logic [pcWidth-1:0] pc;
	logic [pcWidth-1:0] target;
	logic redirect;
	logic run;
	logic halt;
	logic imemWe;
	logic [imemAdrxWidth-1:0] imemAdrx;
	logic [31:0] imemData;
	logic [31:0] fetchWord;
	logic [31:0] fetchReg;
	decodeT decoded;
	decodeT decodeNext;
	branchT decodedBranch;
	branchT decodeBranch;
	branchT execBranch;
	branchT wbBranch;

	decodeBus decodeIf ();

	// A halt in decode holds itself there until run drops
	assign halt = decodeIf.ctl.halt;
	assign decodeNext = halt ? decodeIf.ctl : decoded;

	programCounter programCounter_i (
		.clk(clk),
		.reset(reset),
		.run(run),
		.halt(halt),
		.redirect(redirect),
		.target(target),
		.pc(pc)
	);

	instrMem instrMem_i (
		.clk(clk),
		.rdAdrx(pc[pcWidth-1:2]),
		.rdData(fetchWord),
		.we(imemWe),
		.wrAdrx(imemAdrx),
		.wrData(imemData)
	);

	// Fetch register, idle while stopped or halted
	always_ff @(posedge clk) begin
		if (reset || !run || halt) begin
			fetchReg <= '0;
		end else begin
			fetchReg <= fetchWord;
		end
	end

	instrDecoder instrDecoder_i (
		.instruction(fetchReg),
		.ctl(decoded),
		.branch(decodedBranch)
	);

	stageReg #(.payloadT(decodeT), .idleValue(decodeIdle)) decodeStage_i (
		.clk(clk),
		.reset(reset),
		.en(run),
		.d(decodeNext),
		.q(decodeIf.ctl)
	);

	// Branch bundle travels decode, exec, writeback
	stageReg #(.payloadT(branchT), .idleValue(branchIdle)) decodeBranchStage_i (
		.clk(clk),
		.reset(reset),
		.en(run && !halt),
		.d(decodedBranch),
		.q(decodeBranch)
	);

	stageReg #(.payloadT(branchT), .idleValue(branchIdle)) execStage_i (
		.clk(clk),
		.reset(reset),
		.en(run),
		.d(decodeBranch),
		.q(execBranch)
	);

	stageReg #(.payloadT(branchT), .idleValue(branchIdle)) wbStage_i (
		.clk(clk),
		.reset(reset),
		.en(run),
		.d(execBranch),
		.q(wbBranch)
	);

	branchResolve branchResolve_i (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.wbBranch(wbBranch),
		.execZFlag(execZFlag),
		.execRfRdData0(execRfRdData0),
		.redirect(redirect),
		.target(target)
	);

	hostRegs hostRegs_i (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.imemWe(imemWe),
		.imemAdrx(imemAdrx),
		.imemData(imemData),
		.run(run),
		.halt(halt),
		.pc(pc)
	);

	// Decode bundle out to the datapath
	assign decodeRfRdAdrx0 = decodeIf.ctl.rfRdAdrx0;
	assign decodeRfRdAdrx1 = decodeIf.ctl.rfRdAdrx1;
	assign decodeRfWrAdrx = decodeIf.ctl.rfWrAdrx;
	assign decodeAluCtl = decodeIf.ctl.aluCtl;
	assign decodeRfWriteEn = decodeIf.ctl.rfWriteEn;
	assign decodeAluBusBSel = decodeIf.ctl.aluBusBSel;
	assign decodeDmemResultSel = decodeIf.ctl.dmemResultSel;
	assign decodeDmemWrite = decodeIf.ctl.dmemWrite;
	assign decodeRegDest = decodeIf.ctl.regDest;
	assign decodeImmediate = decodeIf.ctl.immediate;

endmodule

//--- tests/tbCpuControl.sv
// Testbench for the CPU control top level
// Host bus tasks, datapath and pipeline model, program image
// Decode field assertions and the closing report
`timescale 1ns/100ps

module tbCpuControl;
	import cpuPkg::*;

	// Host load of about 150 words plus six short runs stays far below this
	localparam int cycleLimit = 4000;

	typedef struct packed {
		logic [31:0] word;
		logic [pcWidth-1:0] pc;
	} slotT;

	logic clk = 1'b0;
	logic reset;
	logic [11:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [11:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic execZFlag;
	logic [pcWidth-1:0] execRfRdData0;
	logic [4:0] decodeRfRdAdrx0;
	logic [4:0] decodeRfRdAdrx1;
	logic [4:0] decodeRfWrAdrx;
	logic [2:0] decodeAluCtl;
	logic decodeRfWriteEn;
	logic decodeAluBusBSel;
	logic decodeDmemResultSel;
	logic decodeDmemWrite;
	logic decodeRegDest;
	logic [15:0] decodeImmediate;

	logic [31:0] img [imemDepth];
	logic [31:0] rngState = 32'h495e_eea1;
	int errors = 0;
	int cycleCount = 0;

	// Reference pipeline state
	slotT fetchSt;
	slotT decSt;
	slotT exSt;
	slotT wbSt;
	logic wbZ;
	logic [pcWidth-1:0] wbData;
	logic [pcWidth-1:0] modelPc;
	logic modelRun;
	decodeT expCtl;

	cpuControl cpuControl_i (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.execZFlag(execZFlag), .execRfRdData0(execRfRdData0),
		.decodeRfRdAdrx0(decodeRfRdAdrx0), .decodeRfRdAdrx1(decodeRfRdAdrx1),
		.decodeRfWrAdrx(decodeRfWrAdrx), .decodeAluCtl(decodeAluCtl),
		.decodeRfWriteEn(decodeRfWriteEn), .decodeAluBusBSel(decodeAluBusBSel),
		.decodeDmemResultSel(decodeDmemResultSel), .decodeDmemWrite(decodeDmemWrite),
		.decodeRegDest(decodeRegDest), .decodeImmediate(decodeImmediate)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rInstr(input logic [5:0] fn, input int rs, rt, rd);
		return {opRType, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic logic [31:0] iInstr(input logic [5:0] op, input int rs, rt,
			input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	// Background words, every address gives a different addi
	function automatic logic [31:0] fillWord(input int idx);
		return {opAddi, 5'(idx), 5'(idx >> 2), 16'(idx * 259 + 16'h1000)};
	endfunction

	// Expected decode controls from the field mapping
	function automatic decodeT ctlRule(input logic [31:0] w);
		decodeT c;
		logic [5:0] op;
		op = w[31:26];
		c = '0;
		c.rfRdAdrx0 = w[25:21];
		c.rfRdAdrx1 = w[20:16];
		c.immediate = w[15:0];
		case (op)
			opRType: begin
				c.rfWrAdrx = w[15:11];
				c.regDest = 1'b1;
				c.rfWriteEn = 1'b1;
				case (w[5:0])
					fnAdd: c.aluCtl = aluAdd;
					fnSub: c.aluCtl = aluSub;
					fnAnd: c.aluCtl = aluAnd;
					fnOr: c.aluCtl = aluOr;
					fnSlt: c.aluCtl = aluSlt;
					default: c = '0;
				endcase
			end
			opAddi, opLw: begin
				c.rfWrAdrx = w[20:16];
				c.rfWriteEn = 1'b1;
				c.aluBusBSel = 1'b1;
				c.dmemResultSel = (op == opLw);
			end
			opSw: begin
				c.aluBusBSel = 1'b1;
				c.dmemWrite = 1'b1;
			end
			opBeqz, opJ, opJr: begin
				// Branches only show their register addresses and immediate
			end
			default: c = '0;
		endcase
		return c;
	endfunction

	task automatic reportField(input string name);
		errors++;
		$display("ERROR %0t: decode %s differs from the decoder rule", $time, name);
	endtask

	// Zero flag stream from the execute stage
	always @(posedge clk) begin
		rngState = xorshift(rngState);
		execZFlag <= rngState[7];
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Simulation failed");
			$finish;
		end
	end

	// Datapath model: PC two cycles ahead of decode, branch acts from writeback
	always @(posedge clk) begin : pipeModel
		logic redirect;
		logic [pcWidth-1:0] target;
		logic [pcWidth-1:0] immWord;
		slotT decNext;
		immWord = {wbSt.word[pcWidth-3:0], 2'b00};
		redirect = 1'b0;
		target = pcWidth'(wbSt.pc + pcWidth'(4) + immWord);
		case (wbSt.word[31:26])
			opJ: begin
				redirect = 1'b1;
				target = immWord;
			end
			opJr: begin
				redirect = 1'b1;
				target = {wbData[pcWidth-1:2], 2'b00};
			end
			opBeqz: redirect = wbZ;
			default: redirect = 1'b0;
		endcase
		decNext = decSt;
		wbZ <= execZFlag;
		wbData <= execRfRdData0;
		if (reset || !modelRun) begin
			fetchSt <= '0;
			decNext = '0;
			exSt <= '0;
			wbSt <= '0;
			modelPc <= '0;
		end else begin
			wbSt <= exSt;
			exSt <= decSt;
			if (decSt.word[31:26] == opHalt) begin
				// Halt sits in decode, PC frozen, nothing fetched
				fetchSt <= '0;
			end else begin
				decNext = fetchSt;
				fetchSt <= '{word: img[modelPc[pcWidth-1:2]], pc: modelPc};
				modelPc <= redirect ? target : pcWidth'(modelPc + pcWidth'(4));
			end
		end
		decSt <= decNext;
		expCtl <= ctlRule(decNext.word);
		if (reset) begin
			modelRun <= 1'b0;
		end else if (awvalid && awready && wvalid && wready && awaddr == hostCtrlAddr
				&& wstrb[0]) begin
			modelRun <= wdata[0];
		end
	end

	chkRdAdrx0: assert property (@(posedge clk) disable iff (reset)
		decodeRfRdAdrx0 == expCtl.rfRdAdrx0) else reportField("rfRdAdrx0");
	chkRdAdrx1: assert property (@(posedge clk) disable iff (reset)
		decodeRfRdAdrx1 == expCtl.rfRdAdrx1) else reportField("rfRdAdrx1");
	chkWrAdrx: assert property (@(posedge clk) disable iff (reset)
		decodeRfWrAdrx == expCtl.rfWrAdrx) else reportField("rfWrAdrx");
	chkAluCtl: assert property (@(posedge clk) disable iff (reset)
		decodeAluCtl == expCtl.aluCtl) else reportField("aluCtl");
	chkWriteEn: assert property (@(posedge clk) disable iff (reset)
		decodeRfWriteEn == expCtl.rfWriteEn) else reportField("rfWriteEn");
	chkBusBSel: assert property (@(posedge clk) disable iff (reset)
		decodeAluBusBSel == expCtl.aluBusBSel) else reportField("aluBusBSel");
	chkResultSel: assert property (@(posedge clk) disable iff (reset)
		decodeDmemResultSel == expCtl.dmemResultSel) else reportField("dmemResultSel");
	chkDmemWrite: assert property (@(posedge clk) disable iff (reset)
		decodeDmemWrite == expCtl.dmemWrite) else reportField("dmemWrite");
	chkRegDest: assert property (@(posedge clk) disable iff (reset)
		decodeRegDest == expCtl.regDest) else reportField("regDest");
	chkImmediate: assert property (@(posedge clk) disable iff (reset)
		decodeImmediate == expCtl.immediate) else reportField("immediate");

	idleAfterReset: assert property (@(posedge clk)
		reset |=> !(awready || wready || bvalid || arready || rvalid))
		else begin
			errors++;
			$display("ERROR %0t: host handshake outputs not idle after reset", $time);
		end

	task automatic axiWrite(input logic [11:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clk);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wstrb <= 4'hF;
		wvalid <= 1'b1;
		@(posedge clk);
		while (!(awready && wready)) @(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		@(posedge clk);
		while (!bvalid) @(posedge clk);
		resp = bresp;
	endtask

	task automatic axiRead(input logic [11:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		@(posedge clk);
		while (!arready) @(posedge clk);
		arvalid <= 1'b0;
		@(posedge clk);
		while (!rvalid) @(posedge clk);
		data = rdata;
		resp = rresp;
	endtask

	task automatic writeExpect(input logic [11:0] addr, input logic [31:0] data,
			input logic [1:0] expResp);
		logic [1:0] resp;
		axiWrite(addr, data, resp);
		assert (resp == expResp) else begin
			errors++;
			$display("ERROR %0t: write to %h answered %b, expected %b",
				$time, addr, resp, expResp);
		end
	endtask

	task automatic readExpect(input logic [11:0] addr, input logic [31:0] expData);
		logic [31:0] data;
		logic [1:0] resp;
		axiRead(addr, data, resp);
		assert (data == expData && resp == respOkay) else begin
			errors++;
			$display("ERROR %0t: read of %h gave %h resp %b, expected %h OKAY",
				$time, addr, data, resp, expData);
		end
	endtask

	task automatic loadWord(input int idx, input logic [31:0] w);
		img[idx] = w;
		writeExpect(hostImemBase + 12'(idx << 2), w, respOkay);
	endtask

	task automatic waitHalted();
		logic [31:0] data;
		logic [1:0] resp;
		data = '0;
		while (!data[0]) axiRead(hostStatusAddr, data, resp);
	endtask

	// Straight line, then j, jr and beqz with four following words each
	task automatic loadProgram();
		loadWord(0, rInstr(fnAdd, 1, 2, 3));
		loadWord(1, rInstr(fnSub, 4, 5, 6));
		loadWord(2, rInstr(fnAnd, 7, 8, 9));
		loadWord(3, rInstr(fnOr, 10, 11, 12));
		loadWord(4, rInstr(fnSlt, 13, 14, 15));
		loadWord(5, iInstr(opAddi, 1, 16, 16'hfff0));
		loadWord(6, iInstr(opLw, 2, 17, 16'h0040));
		loadWord(7, iInstr(opSw, 3, 18, 16'h0044));
		loadWord(8, iInstr(opJ, 0, 0, 16'd16));
		loadWord(9, rInstr(fnAdd, 19, 20, 21));
		loadWord(10, iInstr(opAddi, 22, 23, 16'h0007));
		loadWord(11, rInstr(fnOr, 24, 25, 26));
		loadWord(12, iInstr(opLw, 27, 28, 16'h0010));
		loadWord(16, iInstr(opAddi, 29, 30, 16'h0123));
		loadWord(17, iInstr(opJr, 31, 0, 16'h0000));
		loadWord(18, rInstr(fnSlt, 1, 2, 3));
		loadWord(19, iInstr(opSw, 4, 5, 16'h0008));
		loadWord(20, rInstr(fnSub, 6, 7, 8));
		loadWord(21, iInstr(opAddi, 9, 10, 16'h8000));
		// jr lands here, beqz goes to 0xA4 or falls through to 0x94
		loadWord(32, iInstr(opBeqz, 11, 0, 16'd8));
		loadWord(33, rInstr(fnAnd, 12, 13, 14));
		loadWord(34, iInstr(opLw, 15, 16, 16'h0004));
		loadWord(35, rInstr(fnAdd, 17, 18, 19));
		loadWord(36, iInstr(opAddi, 20, 21, 16'h0001));
		loadWord(37, iInstr(opAddi, 22, 23, 16'h0055));
		loadWord(38, {opHalt, 26'd0});
		loadWord(41, iInstr(opSw, 24, 25, 16'h00a4));
		loadWord(42, {opHalt, 26'd0});
	endtask

	initial begin
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		execZFlag = 1'b0;
		execRfRdData0 = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < imemDepth; i++) begin
			loadWord(i, fillWord(i));
		end
		loadProgram();

		// Host registers while stopped
		writeExpect(hostCtrlAddr, 32'h0, respOkay);
		readExpect(hostCtrlAddr, 32'h0);
		readExpect(hostStatusAddr, 32'h0);
		writeExpect(12'h300, 32'hdead_beef, respSlvErr);

		// jr target supplied by the register file
		execRfRdData0 <= 9'h080;
		for (int n = 0; n < 6; n++) begin
			writeExpect(hostCtrlAddr, 32'h1, respOkay);
			readExpect(hostCtrlAddr, 32'h1);
			waitHalted();
			readExpect(hostStatusAddr, {14'b0, modelPc, 8'b0, 1'b1});
			writeExpect(hostCtrlAddr, 32'h0, respOkay);
			readExpect(hostStatusAddr, 32'h0);
		end
		repeat (4) @(posedge clk);

		$display("Run finished after %0d cycles with %0d errors", cycleCount, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
design/cpuPkg.sv
design/decodeBus.sv
design/stageReg.sv
design/programCounter.sv
design/instrMem.sv
design/instrDecoder.sv
design/branchResolve.sv
design/hostRegs.sv
design/cpuControl.sv
tests/tbCpuControl.sv

//--- run.sh
#!/bin/sh
# Build and run the control path testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module tbCpuControl -o simCpuControl
./obj_dir/simCpuControl | tee sim.log
grep -q "^Simulation passed$" sim.log
